// ==== src/mem_bus_pkg.sv ====
// Constants and packed structs for the line-wide memory bus side.
// Bus reads return a whole cache line, bus writes carry a single word
// with byte enables. The bus ID packs the cache transaction ID together
// with a one-bit request kind, so that responses can be routed back.
// Import with a wildcard in the module header of any bus-side block.

package mem_bus_pkg;

  localparam int unsigned ADDR_WIDTH = 64;
  localparam int unsigned WORD_WIDTH = 64;
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned BLEN_WIDTH = 2;
  localparam int unsigned TID_WIDTH  = 2;

  // kind of transaction, encoded in the low bit of the bus ID
  typedef enum logic {
    IFILL = 1'b0,
    STD   = 1'b1
  } tx_kind_e;

  typedef struct packed {
    logic [TID_WIDTH-1:0] tid;
    tx_kind_e             kind;
  } bus_id_t;

  typedef logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] addr;
    logic [BLEN_WIDTH-1:0] blen;
    logic [1:0]            size;
    bus_id_t               id;
  } bus_rd_req_t;

  // writes are always single-word
  typedef struct packed {
    logic [ADDR_WIDTH-1:0]   addr;
    logic [WORD_WIDTH-1:0]   data;
    logic [WORD_WIDTH/8-1:0] be;
    logic [1:0]              size;
    bus_id_t                 id;
  } bus_wr_req_t;

  typedef struct packed {
    bus_id_t id;
    line_t   data;
  } bus_rd_rsp_t;

  typedef struct packed {
    bus_id_t id;
  } bus_wr_rsp_t;

endpackage

// ==== src/cache_msg_pkg.sv ====
// Cache-side message formats shared by the L1 caches and the adapter.
// Holds the request structs pushed by the instruction and data cache,
// the return structs sent back to them, and the byte-enable helper
// used to turn a store address and size into bus byte lanes.

package cache_msg_pkg;

  import mem_bus_pkg::*;

  localparam int unsigned REQ_FIFO_DEPTH = 2;

  typedef enum logic {
    LOAD  = 1'b0,
    STORE = 1'b1
  } dcache_rtype_e;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] paddr;
    logic                  nc;
    logic [TID_WIDTH-1:0]  tid;
  } icache_req_t;

  // size bit 2 asks for a full line, the low bits give the word size
  typedef struct packed {
    dcache_rtype_e         rtype;
    logic [2:0]            size;
    logic [ADDR_WIDTH-1:0] paddr;
    logic [WORD_WIDTH-1:0] data;
    logic [TID_WIDTH-1:0]  tid;
  } dcache_req_t;

  typedef enum logic [1:0] {
    IFILL_ACK = 2'd0,
    LOAD_ACK  = 2'd1,
    STORE_ACK = 2'd2
  } rtrn_type_e;

  typedef struct packed {
    rtrn_type_e           rtype;
    logic [TID_WIDTH-1:0] tid;
    line_t                data;
  } icache_rtrn_t;

  typedef struct packed {
    rtrn_type_e           rtype;
    logic [TID_WIDTH-1:0] tid;
    line_t                data;
  } dcache_rtrn_t;

  // byte lanes of a 64 bit word touched by an access of 2**size bytes
  function automatic logic [7:0] byte_enable_8(input logic [2:0] off, input logic [1:0] size);
    logic [7:0] be;
    unique case (size)
      2'b00:   be = 8'h01 << off;
      2'b01:   be = 8'h03 << {off[2:1], 1'b0};
      2'b10:   be = 8'h0f << {off[2], 2'b00};
      default: be = 8'hff;
    endcase
    return be;
  endfunction

endpackage

// ==== src/req_fifo.sv ====
// Small circular request buffer with a registered storage array.
// The entry type is a parameter, so the same block buffers both the
// instruction and the data cache requests. The head entry is visible
// on data_o whenever empty_o is low; pop_i removes it.

`timescale 1ns/100ps

module req_fifo #(
  parameter type         entry_t = logic,
  parameter int unsigned DEPTH   = 2
) (
  input  logic   clk_i,
  input  logic   rst_ni,
  input  logic   push_i,
  input  entry_t data_i,
  input  logic   pop_i,
  output entry_t data_o,
  output logic   full_o,
  output logic   empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  entry_t            mem_q [DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0]  cnt_q;

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (cnt_q == CNT_FULL);
  assign empty_o = (cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_ctrl
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_LAST) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == PTR_LAST) ? '0 : rd_ptr_q + 1'b1;
      end
      unique case ({push_i, pop_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin : p_mem
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // the writer must gate its push with full_o
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni) push_i |-> !full_o)
    else $error("push into full request FIFO");

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni) pop_i |-> !empty_o)
    else $error("pop from empty request FIFO");

endmodule

// ==== src/req_intake.sv ====
// Input side of the adapter. Each cache pushes into its own request
// FIFO, acknowledged in the same cycle unless that FIFO is full.
// A two-way round-robin picks one FIFO head and keeps that choice
// until the request builder takes it, then pops the winning FIFO.

`timescale 1ns/100ps

module req_intake import cache_msg_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        icache_req_i,
  input  icache_req_t icache_data_i,
  output logic        icache_ack_o,
  input  logic        dcache_req_i,
  input  dcache_req_t dcache_data_i,
  output logic        dcache_ack_o,
  input  logic        sel_take_i,
  output logic        sel_valid_o,
  output logic        sel_is_dcache_o,
  output icache_req_t icache_head_o,
  output dcache_req_t dcache_head_o
);

  logic icache_full, icache_empty;
  logic dcache_full, dcache_empty;
  logic last_dcache_q;
  logic lock_q, lock_sel_q;
  logic pick_dcache;

  assign icache_ack_o = icache_req_i & ~icache_full;
  assign dcache_ack_o = dcache_req_i & ~dcache_full;

  req_fifo #(.entry_t(icache_req_t), .DEPTH(REQ_FIFO_DEPTH)) i_icache_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (icache_ack_o),
    .data_i  (icache_data_i),
    .pop_i   (sel_take_i & ~sel_is_dcache_o),
    .data_o  (icache_head_o),
    .full_o  (icache_full),
    .empty_o (icache_empty)
  );

  req_fifo #(.entry_t(dcache_req_t), .DEPTH(REQ_FIFO_DEPTH)) i_dcache_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (dcache_ack_o),
    .data_i  (dcache_data_i),
    .pop_i   (sel_take_i & sel_is_dcache_o),
    .data_o  (dcache_head_o),
    .full_o  (dcache_full),
    .empty_o (dcache_empty)
  );

  ////////////////////////////////////////////////////////////
  // round-robin selection
  ////////////////////////////////////////////////////////////

  // with both waiting, the source that did not win last time goes next
  assign pick_dcache     = dcache_empty ? 1'b0 : (icache_empty | ~last_dcache_q);
  assign sel_valid_o     = ~icache_empty | ~dcache_empty;
  assign sel_is_dcache_o = lock_q ? lock_sel_q : pick_dcache;

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_arb
    if (!rst_ni) begin
      last_dcache_q <= 1'b0;
      lock_q        <= 1'b0;
      lock_sel_q    <= 1'b0;
    end else begin
      lock_q     <= sel_valid_o & ~sel_take_i;
      lock_sel_q <= sel_is_dcache_o;
      if (sel_take_i) begin
        last_dcache_q <= sel_is_dcache_o;
      end
    end
  end

endmodule

// ==== src/bus_req_builder.sv ====
// Request processing. Turns the selected FIFO head into a bus read
// (instruction fill or data load) or a bus write (data store).
// Bus fields are held stable until the matching grant, which also
// takes the request from the intake. Only one read may be in flight,
// so a new read is withheld until the previous read response arrives.

`timescale 1ns/100ps

module bus_req_builder import mem_bus_pkg::*, cache_msg_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        sel_valid_i,
  input  logic        sel_is_dcache_i,
  input  icache_req_t icache_head_i,
  input  dcache_req_t dcache_head_i,
  output logic        sel_take_o,
  output logic        rd_req_o,
  output bus_rd_req_t rd_o,
  input  logic        rd_gnt_i,
  output logic        wr_req_o,
  output bus_wr_req_t wr_o,
  input  logic        wr_gnt_i,
  input  logic        rd_done_i
);

  localparam logic [BLEN_WIDTH-1:0] BLEN_LINE = BLEN_WIDTH'(LINE_WORDS - 1);

  logic rd_pending_q;
  logic is_store;

  assign is_store = (dcache_head_i.rtype == STORE);

  ////////////////////////////////////////////////////////////
  // request decode
  ////////////////////////////////////////////////////////////

  always_comb begin : p_rd_fields
    if (sel_is_dcache_i) begin
      rd_o.addr    = dcache_head_i.paddr;
      rd_o.size    = dcache_head_i.size[1:0];
      rd_o.blen    = dcache_head_i.size[2] ? BLEN_LINE : '0;
      rd_o.id.tid  = dcache_head_i.tid;
      rd_o.id.kind = STD;
    end else begin
      rd_o.addr    = icache_head_i.paddr;
      // fills always use full 64 bit beats
      rd_o.size    = 2'b11;
      rd_o.blen    = icache_head_i.nc ? '0 : BLEN_LINE;
      rd_o.id.tid  = icache_head_i.tid;
      rd_o.id.kind = IFILL;
    end
  end

  // stores are single-word writes
  always_comb begin : p_wr_fields
    wr_o.addr    = dcache_head_i.paddr;
    wr_o.data    = dcache_head_i.data;
    wr_o.be      = byte_enable_8(dcache_head_i.paddr[2:0], dcache_head_i.size[1:0]);
    wr_o.size    = dcache_head_i.size[1:0];
    wr_o.id.tid  = dcache_head_i.tid;
    wr_o.id.kind = STD;
  end

  assign rd_req_o   = sel_valid_i & ~rd_pending_q & ~(sel_is_dcache_i & is_store);
  assign wr_req_o   = sel_valid_i & sel_is_dcache_i & is_store;
  assign sel_take_o = (rd_req_o & rd_gnt_i) | (wr_req_o & wr_gnt_i);

  ////////////////////////////////////////////////////////////
  // outstanding read
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_pending
    if (!rst_ni) begin
      rd_pending_q <= 1'b0;
    end else if (rd_req_o && rd_gnt_i) begin
      rd_pending_q <= 1'b1;
    end else if (rd_done_i) begin
      rd_pending_q <= 1'b0;
    end
  end

  // a read response is only legal for a granted read
  a_done_pending: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_done_i |-> rd_pending_q)
    else $error("read response without a pending read");

  // the intake lock keeps an ungranted read request stable
  a_rd_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req_o && !rd_gnt_i |=> rd_req_o && $stable(rd_o))
    else $error("read request changed before grant");

endmodule

// ==== src/rtrn_router.sv ====
// Output side. Decodes bus responses by the kind bit of their ID and
// forwards them in the same cycle to the instruction or data cache.
// Read responses win; a write response waiting in the same cycle is
// held off through wr_rsp_rdy_o. The caches never stall a return.

`timescale 1ns/100ps

module rtrn_router import mem_bus_pkg::*, cache_msg_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         rd_rsp_valid_i,
  input  bus_rd_rsp_t  rd_rsp_i,
  input  logic         wr_rsp_valid_i,
  input  bus_wr_rsp_t  wr_rsp_i,
  output logic         wr_rsp_rdy_o,
  output logic         icache_rtrn_vld_o,
  output icache_rtrn_t icache_rtrn_o,
  output logic         dcache_rtrn_vld_o,
  output dcache_rtrn_t dcache_rtrn_o
);

  assign wr_rsp_rdy_o = ~rd_rsp_valid_i;

  always_comb begin : p_route
    icache_rtrn_vld_o   = 1'b0;
    dcache_rtrn_vld_o   = 1'b0;
    icache_rtrn_o       = '0;
    dcache_rtrn_o       = '0;
    icache_rtrn_o.rtype = IFILL_ACK;
    icache_rtrn_o.tid   = rd_rsp_i.id.tid;
    icache_rtrn_o.data  = rd_rsp_i.data;

    if (rd_rsp_valid_i) begin
      unique case (rd_rsp_i.id.kind)
        IFILL: begin
          icache_rtrn_vld_o = 1'b1;
        end
        STD: begin
          dcache_rtrn_vld_o   = 1'b1;
          dcache_rtrn_o.rtype = LOAD_ACK;
          dcache_rtrn_o.tid   = rd_rsp_i.id.tid;
          dcache_rtrn_o.data  = rd_rsp_i.data;
        end
      endcase
    end else if (wr_rsp_valid_i) begin
      // store acks carry no data
      dcache_rtrn_vld_o   = 1'b1;
      dcache_rtrn_o.rtype = STORE_ACK;
      dcache_rtrn_o.tid   = wr_rsp_i.id.tid;
    end
  end

  a_one_rtrn: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(icache_rtrn_vld_o && dcache_rtrn_vld_o))
    else $error("returns to both caches in one cycle");

  // the bus keeps a held-off write response until it is accepted
  a_wr_rsp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_rsp_valid_i && !wr_rsp_rdy_o |=> wr_rsp_valid_i && $stable(wr_rsp_i))
    else $error("write response dropped while held off");

endmodule

// ==== src/cache_bus_adapter.sv ====
// Top level of the L1 cache to line-bus adapter. Connects the request
// intake (FIFOs and arbiter), the bus request builder and the return
// router. The cache ports use req/ack, the bus ports req/gnt with
// single-cycle read responses and held write responses.

`timescale 1ns/100ps

module cache_bus_adapter import mem_bus_pkg::*, cache_msg_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  // icache
  input  logic         icache_req_i,
  input  icache_req_t  icache_data_i,
  output logic         icache_ack_o,
  output logic         icache_rtrn_vld_o,
  output icache_rtrn_t icache_rtrn_o,
  // dcache
  input  logic         dcache_req_i,
  input  dcache_req_t  dcache_data_i,
  output logic         dcache_ack_o,
  output logic         dcache_rtrn_vld_o,
  output dcache_rtrn_t dcache_rtrn_o,
  // line bus
  output logic         rd_req_o,
  output bus_rd_req_t  rd_o,
  input  logic         rd_gnt_i,
  output logic         wr_req_o,
  output bus_wr_req_t  wr_o,
  input  logic         wr_gnt_i,
  input  logic         rd_rsp_valid_i,
  input  bus_rd_rsp_t  rd_rsp_i,
  input  logic         wr_rsp_valid_i,
  input  bus_wr_rsp_t  wr_rsp_i,
  output logic         wr_rsp_rdy_o
);

  logic        sel_valid, sel_is_dcache, sel_take;
  icache_req_t icache_head;
  dcache_req_t dcache_head;

  req_intake i_intake (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .icache_req_i    (icache_req_i),
    .icache_data_i   (icache_data_i),
    .icache_ack_o    (icache_ack_o),
    .dcache_req_i    (dcache_req_i),
    .dcache_data_i   (dcache_data_i),
    .dcache_ack_o    (dcache_ack_o),
    .sel_take_i      (sel_take),
    .sel_valid_o     (sel_valid),
    .sel_is_dcache_o (sel_is_dcache),
    .icache_head_o   (icache_head),
    .dcache_head_o   (dcache_head)
  );

  bus_req_builder i_builder (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .sel_valid_i     (sel_valid),
    .sel_is_dcache_i (sel_is_dcache),
    .icache_head_i   (icache_head),
    .dcache_head_i   (dcache_head),
    .sel_take_o      (sel_take),
    .rd_req_o        (rd_req_o),
    .rd_o            (rd_o),
    .rd_gnt_i        (rd_gnt_i),
    .wr_req_o        (wr_req_o),
    .wr_o            (wr_o),
    .wr_gnt_i        (wr_gnt_i),
    // every read response closes the single outstanding read
    .rd_done_i       (rd_rsp_valid_i)
  );

  rtrn_router i_router (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .rd_rsp_valid_i    (rd_rsp_valid_i),
    .rd_rsp_i          (rd_rsp_i),
    .wr_rsp_valid_i    (wr_rsp_valid_i),
    .wr_rsp_i          (wr_rsp_i),
    .wr_rsp_rdy_o      (wr_rsp_rdy_o),
    .icache_rtrn_vld_o (icache_rtrn_vld_o),
    .icache_rtrn_o     (icache_rtrn_o),
    .dcache_rtrn_vld_o (dcache_rtrn_vld_o),
    .dcache_rtrn_o     (dcache_rtrn_o)
  );

endmodule

// ==== bench/tb_clk_gen.sv ====
// Clock and reset source for the adapter testbench.
// Drives a free-running clock and holds the active-low reset
// for a fixed number of rising edges after time zero.

`timescale 1ns/100ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS  = 10,
  parameter int unsigned RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin : p_clk
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin : p_rst
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// ==== bench/bus_mem_model.sv ====
// Line-bus responder for the adapter testbench.
// Grants reads and writes after pseudo-random delays, answers reads with
// a whole line captured at grant time and returns write responses in
// grant order, held until the adapter accepts them.
// Memory content starts as a fill pattern of the word address.

`timescale 1ns/100ps

module bus_mem_model import mem_bus_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        rd_req_i,
  input  bus_rd_req_t rd_i,
  output logic        rd_gnt_o,
  input  logic        wr_req_i,
  input  bus_wr_req_t wr_i,
  output logic        wr_gnt_o,
  output logic        rd_rsp_valid_o,
  output bus_rd_rsp_t rd_rsp_o,
  output logic        wr_rsp_valid_o,
  output bus_wr_rsp_t wr_rsp_o,
  input  logic        wr_rsp_rdy_i,
  output int          proto_errs_o
);

  logic [63:0] mem [logic [63:0]];
  logic [15:0] lfsr_q = 16'd28;
  bus_wr_rsp_t wr_rsp_q [$];
  bit          rd_busy;
  bus_id_t     rd_id;
  line_t       rd_line;
  int          rd_wait, wr_wait, rsp_wait, wrsp_wait;
  int          proto_errs;

  assign proto_errs_o = proto_errs;

  // same pattern as the reference memory of the testbench
  function automatic logic [63:0] init_word(input logic [63:0] a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ (a >> 29) ^ 64'h0123_4567_89ab_cdef;
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      r = (r << 1) | lfsr_q[0];
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic logic [63:0] read_word(input logic [63:0] idx);
    return mem.exists(idx) ? mem[idx] : init_word(idx << 3);
  endfunction

  function automatic line_t read_line(input logic [63:0] addr);
    line_t l;
    for (int w = 0; w < LINE_WORDS; w++) begin
      l[w] = read_word(((addr >> 5) << 2) + w);
    end
    return l;
  endfunction

  always @(posedge clk_i or negedge rst_ni) begin : p_bus
    logic [63:0] idx;
    logic [63:0] word;
    if (!rst_ni) begin
      rd_gnt_o       <= 1'b0;
      wr_gnt_o       <= 1'b0;
      rd_rsp_valid_o <= 1'b0;
      rd_rsp_o       <= '0;
      wr_rsp_valid_o <= 1'b0;
      wr_rsp_o       <= '0;
      rd_busy = 1'b0;
      wr_rsp_q.delete();
      rd_wait = 0;
      wr_wait = 0;
      rsp_wait = 0;
      wrsp_wait = 0;
      proto_errs = 0;
    end else begin
      //////////////////////////////////////////////////////////
      // reads
      //////////////////////////////////////////////////////////
      rd_rsp_valid_o <= 1'b0;
      if (rd_busy) begin
        if (rsp_wait == 0) begin
          rd_rsp_valid_o <= 1'b1;
          rd_rsp_o       <= '{id: rd_id, data: rd_line};
          rd_busy = 1'b0;
        end else begin
          rsp_wait--;
        end
      end
      if (rd_gnt_o) begin
        rd_gnt_o <= 1'b0;
        if (rd_busy) begin
          $display("bus model: a second read was granted while one is outstanding");
          proto_errs++;
        end
        rd_busy = 1'b1;
        rd_id = rd_i.id;
        rd_line = read_line(rd_i.addr);
        rsp_wait = take_bits(3);
      end else if (rd_req_i) begin
        if (rd_wait == 0) begin
          rd_gnt_o <= 1'b1;
          rd_wait = take_bits(2);
        end else begin
          rd_wait--;
        end
      end
      //////////////////////////////////////////////////////////
      // writes
      //////////////////////////////////////////////////////////
      if (wr_gnt_o) begin
        wr_gnt_o <= 1'b0;
        idx = wr_i.addr >> 3;
        word = read_word(idx);
        for (int b = 0; b < 8; b++) begin
          if (wr_i.be[b]) word[8*b +: 8] = wr_i.data[8*b +: 8];
        end
        mem[idx] = word;
        wr_rsp_q.push_back('{id: wr_i.id});
      end else if (wr_req_i) begin
        if (wr_wait == 0) begin
          wr_gnt_o <= 1'b1;
          wr_wait = take_bits(2);
        end else begin
          wr_wait--;
        end
      end
      // write response stays up until the adapter takes it
      if (wr_rsp_valid_o && wr_rsp_rdy_i) begin
        wr_rsp_valid_o <= 1'b0;
        wrsp_wait = take_bits(2);
      end else if (!wr_rsp_valid_o && wr_rsp_q.size() > 0) begin
        if (wrsp_wait == 0) begin
          wr_rsp_valid_o <= 1'b1;
          wr_rsp_o       <= wr_rsp_q.pop_front();
        end else begin
          wrsp_wait--;
        end
      end
    end
  end

endmodule

// ==== bench/cache_bus_adapter_tb.sv ====
// Testbench top for the cache to line-bus adapter.
// Drives directed and pseudo-random cache requests, checks every bus
// request at its grant and every cache return against a reference
// model of the request rules and of the memory contents.

`timescale 1ns/100ps

module cache_bus_adapter_tb import mem_bus_pkg::*, cache_msg_pkg::*;;

  localparam int TIMEOUT = 500;

  logic clk, rst_n;
  logic icache_req, icache_ack, icache_rtrn_vld;
  logic dcache_req, dcache_ack, dcache_rtrn_vld;
  icache_req_t  icache_data;
  dcache_req_t  dcache_data;
  icache_rtrn_t icache_rtrn;
  dcache_rtrn_t dcache_rtrn;
  logic rd_req, rd_gnt, wr_req, wr_gnt, rd_rsp_valid, wr_rsp_valid, wr_rsp_rdy;
  bus_rd_req_t rd;
  bus_wr_req_t wr;
  bus_rd_rsp_t rd_rsp;
  bus_wr_rsp_t wr_rsp;
  int proto_errs;

  // expected traffic and reference memory
  icache_req_t  exp_iq [$];
  dcache_req_t  exp_dq [$];
  icache_rtrn_t ret_iq [$];
  dcache_rtrn_t ret_lq [$];
  dcache_rtrn_t ret_sq [$];
  icache_req_t  rand_iq [$];
  dcache_req_t  rand_dq [$];
  logic [63:0]  ref_mem [logic [63:0]];
  logic [15:0]  lfsr_q = 16'd28;
  int err_cnt, plain_errs, ack_cnt, rtrn_cnt;
  bit started, rd_busy;

  tb_clk_gen clk_gen_i (.clk_o(clk), .rst_no(rst_n));

  bus_mem_model mem_i (
    .clk_i(clk), .rst_ni(rst_n), .rd_req_i(rd_req), .rd_i(rd), .rd_gnt_o(rd_gnt),
    .wr_req_i(wr_req), .wr_i(wr), .wr_gnt_o(wr_gnt), .rd_rsp_valid_o(rd_rsp_valid),
    .rd_rsp_o(rd_rsp), .wr_rsp_valid_o(wr_rsp_valid), .wr_rsp_o(wr_rsp),
    .wr_rsp_rdy_i(wr_rsp_rdy), .proto_errs_o(proto_errs)
  );

  cache_bus_adapter dut_i (
    .clk_i(clk), .rst_ni(rst_n),
    .icache_req_i(icache_req), .icache_data_i(icache_data), .icache_ack_o(icache_ack),
    .icache_rtrn_vld_o(icache_rtrn_vld), .icache_rtrn_o(icache_rtrn),
    .dcache_req_i(dcache_req), .dcache_data_i(dcache_data), .dcache_ack_o(dcache_ack),
    .dcache_rtrn_vld_o(dcache_rtrn_vld), .dcache_rtrn_o(dcache_rtrn),
    .rd_req_o(rd_req), .rd_o(rd), .rd_gnt_i(rd_gnt), .wr_req_o(wr_req), .wr_o(wr),
    .wr_gnt_i(wr_gnt), .rd_rsp_valid_i(rd_rsp_valid), .rd_rsp_i(rd_rsp),
    .wr_rsp_valid_i(wr_rsp_valid), .wr_rsp_i(wr_rsp), .wr_rsp_rdy_o(wr_rsp_rdy)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic int unsigned take_bits(input int n);
    int unsigned r;
    r = 0;
    for (int i = 0; i < n; i++) begin
      r = (r << 1) | lfsr_q[0];
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hb400) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic logic [63:0] fill_word(input logic [63:0] a);
    return (a * 64'h9e37_79b9_7f4a_7c15) ^ (a >> 29) ^ 64'h0123_4567_89ab_cdef;
  endfunction

  function automatic line_t ref_line(input logic [63:0] addr);
    line_t l;
    logic [63:0] idx;
    for (int w = 0; w < LINE_WORDS; w++) begin
      idx = ((addr >> 5) << 2) + w;
      l[w] = ref_mem.exists(idx) ? ref_mem[idx] : fill_word(idx << 3);
    end
    return l;
  endfunction

  // lanes of an aligned access of 2**size bytes that holds the offset
  function automatic logic [7:0] expect_be(input logic [2:0] off, input logic [1:0] size);
    logic [7:0] be;
    int n, base;
    n = 1 << size;
    base = off & ~(n - 1);
    for (int i = 0; i < 8; i++) be[i] = (i >= base) && (i < base + n);
    return be;
  endfunction

  function automatic bus_rd_req_t expect_fill(input icache_req_t r);
    bus_rd_req_t b;
    b.addr = r.paddr;
    b.blen = r.nc ? 2'd0 : 2'd3;
    b.size = 2'd3;
    b.id   = '{tid: r.tid, kind: IFILL};
    return b;
  endfunction

  function automatic bus_rd_req_t expect_load(input dcache_req_t r);
    bus_rd_req_t b;
    b.addr = r.paddr;
    b.blen = r.size[2] ? 2'd3 : 2'd0;
    b.size = r.size[1:0];
    b.id   = '{tid: r.tid, kind: STD};
    return b;
  endfunction

  function automatic bus_wr_req_t expect_store(input dcache_req_t r);
    bus_wr_req_t b;
    b.addr = r.paddr;
    b.data = r.data;
    b.be   = expect_be(r.paddr[2:0], r.size[1:0]);
    b.size = r.size[1:0];
    b.id   = '{tid: r.tid, kind: STD};
    return b;
  endfunction

  task automatic check_eq(input string what, input logic [259:0] act, input logic [259:0] exp);
    if (act !== exp) begin
      $display("** Error @ %0t: %s expected %h got %h", $time, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s", what);
    $display("*** TEST FAILED ***");
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // compare process sampled at the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin : p_compare
    bus_wr_req_t w;
    logic [63:0] idx;
    line_t       cur;
    if (!started) begin
      check_eq("idle outputs", {rd_req, wr_req, icache_rtrn_vld, dcache_rtrn_vld}, '0);
    end
    if (rd_rsp_valid && wr_rsp_rdy) begin
      $display("write response ready in a cycle with a read response at %0t", $time);
      plain_errs++;
    end
    if (wr_rsp_valid && wr_rsp_rdy &&
        !(dcache_rtrn_vld && dcache_rtrn.rtype == STORE_ACK)) begin
      $display("write response accepted without a store return at %0t", $time);
      plain_errs++;
    end
    if (icache_rtrn_vld) begin
      rtrn_cnt++;
      if (ret_iq.size() == 0) begin
        $display("unexpected icache return at %0t", $time);
        plain_errs++;
      end else begin
        check_eq("icache return", icache_rtrn, ret_iq.pop_front());
      end
    end
    if (dcache_rtrn_vld) begin
      rtrn_cnt++;
      if (dcache_rtrn.rtype == STORE_ACK) begin
        if (rd_rsp_valid) begin
          $display("store return in a cycle with a read response at %0t", $time);
          plain_errs++;
        end
        if (ret_sq.size() == 0) begin
          $display("unexpected store return at %0t", $time);
          plain_errs++;
        end else begin
          check_eq("store return", dcache_rtrn, ret_sq.pop_front());
        end
      end else if (ret_lq.size() == 0) begin
        $display("unexpected load return at %0t", $time);
        plain_errs++;
      end else begin
        check_eq("load return", dcache_rtrn, ret_lq.pop_front());
      end
    end
    if (rd_rsp_valid) rd_busy = 1'b0;
    if (rd_req && rd_gnt) begin
      if (rd_busy) begin
        $display("two reads in flight at %0t", $time);
        plain_errs++;
      end
      rd_busy = 1'b1;
      if (rd.id.kind == IFILL && exp_iq.size() > 0) begin
        check_eq("fill request", rd, expect_fill(exp_iq[0]));
        ret_iq.push_back('{rtype: IFILL_ACK, tid: exp_iq[0].tid, data: ref_line(exp_iq[0].paddr)});
        void'(exp_iq.pop_front());
      end else if (rd.id.kind == STD && exp_dq.size() > 0 && exp_dq[0].rtype == LOAD) begin
        check_eq("load request", rd, expect_load(exp_dq[0]));
        ret_lq.push_back('{rtype: LOAD_ACK, tid: exp_dq[0].tid, data: ref_line(exp_dq[0].paddr)});
        void'(exp_dq.pop_front());
      end else begin
        $display("read granted with no matching request at %0t", $time);
        plain_errs++;
      end
    end
    if (wr_req && wr_gnt) begin
      if (exp_dq.size() > 0 && exp_dq[0].rtype == STORE) begin
        w = expect_store(exp_dq[0]);
        check_eq("store request", wr, w);
        idx = w.addr >> 3;
        cur = ref_line(w.addr);
        ref_mem[idx] = cur[idx[1:0]];
        for (int b = 0; b < 8; b++) begin
          if (w.be[b]) ref_mem[idx][8*b +: 8] = w.data[8*b +: 8];
        end
        ret_sq.push_back('{rtype: STORE_ACK, tid: w.id.tid, data: '0});
        void'(exp_dq.pop_front());
      end else begin
        $display("write granted with no matching store at %0t", $time);
        plain_errs++;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  task automatic send_icache(input icache_req_t r);
    bit ok;
    @(posedge clk);
    started = 1'b1;
    icache_req  <= 1'b1;
    icache_data <= r;
    ok = 1'b0;
    for (int t = 0; t < TIMEOUT && !ok; t++) begin
      @(negedge clk);
      ok = icache_ack;
    end
    if (!ok) begin
      fail_timeout("icache ack");
    end else begin
      exp_iq.push_back(r);
      ack_cnt++;
    end
  endtask

  task automatic send_dcache(input dcache_req_t r);
    bit ok;
    @(posedge clk);
    started = 1'b1;
    dcache_req  <= 1'b1;
    dcache_data <= r;
    ok = 1'b0;
    for (int t = 0; t < TIMEOUT && !ok; t++) begin
      @(negedge clk);
      ok = dcache_ack;
    end
    if (!ok) begin
      fail_timeout("dcache ack");
    end else begin
      exp_dq.push_back(r);
      ack_cnt++;
    end
  endtask

  task automatic release_reqs();
    @(posedge clk);
    icache_req <= 1'b0;
    dcache_req <= 1'b0;
  endtask

  task automatic wait_drained();
    bit done;
    done = 1'b0;
    for (int t = 0; t < 8 * TIMEOUT && !done; t++) begin
      @(negedge clk);
      done = exp_iq.size() == 0 && exp_dq.size() == 0 && ret_iq.size() == 0 &&
             ret_lq.size() == 0 && ret_sq.size() == 0;
    end
    if (!done) fail_timeout("outstanding returns");
  endtask

  task automatic icache_stream();
    foreach (rand_iq[i]) send_icache(rand_iq[i]);
    @(posedge clk);
    icache_req <= 1'b0;
  endtask

  task automatic dcache_stream();
    foreach (rand_dq[i]) send_dcache(rand_dq[i]);
    @(posedge clk);
    dcache_req <= 1'b0;
  endtask

  task automatic run_directed();
    repeat (4) @(posedge clk);

    // cacheable fill then non-cacheable fill
    send_icache('{paddr: 64'h1000_0040, nc: 1'b0, tid: 2'd1});
    send_icache('{paddr: 64'h1000_0068, nc: 1'b1, tid: 2'd2});
    release_reqs();
    wait_drained();

    // line load, word load, store and a load of the stored line
    send_dcache('{rtype: LOAD, size: 3'b111, paddr: 64'h2000_0020, data: '0, tid: 2'd0});
    send_dcache('{rtype: LOAD, size: 3'b011, paddr: 64'h2000_0028, data: '0, tid: 2'd3});
    send_dcache('{rtype: STORE, size: 3'b001, paddr: 64'h2000_0026,
                  data: 64'hdead_beef_cafe_f00d, tid: 2'd1});
    send_dcache('{rtype: LOAD, size: 3'b100, paddr: 64'h2000_0020, data: '0, tid: 2'd2});
    release_reqs();
    wait_drained();
  endtask

  task automatic run_random();
    icache_req_t ir;
    dcache_req_t dr;
    // random mix; the two caches use disjoint address ranges
    for (int i = 0; i < 40; i++) begin
      ir.paddr = 64'h1000_0000 + (take_bits(3) << 5) + (take_bits(2) << 3);
      ir.nc    = take_bits(1);
      ir.tid   = take_bits(2);
      rand_iq.push_back(ir);
    end
    for (int i = 0; i < 60; i++) begin
      dr.rtype = dcache_rtype_e'(take_bits(1));
      dr.paddr = 64'h2000_0000 + (take_bits(2) << 5) + take_bits(5);
      dr.size  = (dr.rtype == STORE) ? 3'(take_bits(2)) : 3'(take_bits(3));
      dr.data  = {32'(take_bits(32)), 32'(take_bits(32))};
      dr.tid   = take_bits(2);
      rand_dq.push_back(dr);
    end
    fork
      icache_stream();
      dcache_stream();
    join
    wait_drained();
  endtask

  initial begin : p_stim
    icache_req  = 1'b0;
    icache_data = '0;
    dcache_req  = 1'b0;
    dcache_data = '0;
    for (int t = 0; t < TIMEOUT && !rst_n; t++) @(posedge clk);
    if (!rst_n) begin
      fail_timeout("reset release");
    end else begin
      run_directed();
      run_random();
      repeat (4) @(posedge clk);

      check_eq("return count", rtrn_cnt, ack_cnt);
      $display("checks failed: %0d, other errors: %0d, bus model errors: %0d",
               err_cnt, plain_errs, proto_errs);
      if (err_cnt == 0 && plain_errs == 0 && proto_errs == 0) begin
        $display("*** TEST PASSED ***");
      end else begin
        $display("*** TEST FAILED ***");
      end
      $finish;
    end
  end

endmodule

// ==== compile.f ====
src/mem_bus_pkg.sv
src/cache_msg_pkg.sv
src/req_fifo.sv
src/req_intake.sv
src/bus_req_builder.sv
src/rtrn_router.sv
src/cache_bus_adapter.sv
bench/tb_clk_gen.sv
bench/bus_mem_model.sv
bench/cache_bus_adapter_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -Wno-fatal
TOP       := cache_bus_adapter_tb
FLIST     := compile.f
LOG       := sim.log
OBJ_DIR   := obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG); then exit 1; fi
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
